//--- design/i2c_pkg.sv
package i2c_pkg;

    // bus field widths
    localparam int ADDR_W = 7;
    localparam int DATA_W = 8;

    // each bus slot is split into quarter phases of one clock each
    localparam int QUARTERS = 4;
    localparam int PHASE_W = $clog2(QUARTERS);

    // slot kinds understood by the bit engine
    localparam int SLOT_W = 2;
    localparam logic [SLOT_W-1:0] SLOT_IDLE = 2'd0;
    localparam logic [SLOT_W-1:0] SLOT_START = 2'd1;
    localparam logic [SLOT_W-1:0] SLOT_BIT = 2'd2;
    localparam logic [SLOT_W-1:0] SLOT_STOP = 2'd3;

    // frame segments walked by the frame controller
    localparam int SEG_W = 3;
    localparam logic [SEG_W-1:0] SEG_IDLE = 3'd0;
    localparam logic [SEG_W-1:0] SEG_START = 3'd1;
    localparam logic [SEG_W-1:0] SEG_ADDR = 3'd2;
    localparam logic [SEG_W-1:0] SEG_ACK1 = 3'd3;
    localparam logic [SEG_W-1:0] SEG_WRITE = 3'd4;
    localparam logic [SEG_W-1:0] SEG_READ = 3'd5;
    localparam logic [SEG_W-1:0] SEG_ACK2 = 3'd6;
    localparam logic [SEG_W-1:0] SEG_STOP = 3'd7;

endpackage

//--- design/i2c_slot_if.sv
`timescale 1ns/1ps

interface i2c_slot_if;

    // slot request from the frame controller, held for a whole slot
    logic [i2c_pkg::SLOT_W-1:0] slot_kind;
    // sda level for a bit slot, 1 means released
    logic tx_bit;
    // read data slot, engine samples sda
    logic sample_en;

    // last quarter of the running slot
    logic slot_end;
    // sampled sda, valid for one cycle in quarter 3
    logic rx_bit;
    logic rx_valid;

    modport ctrl (
        output slot_kind,
        output tx_bit,
        output sample_en,
        input  slot_end
    );

    modport engine (
        input  slot_kind,
        input  tx_bit,
        input  sample_en,
        output slot_end,
        output rx_bit,
        output rx_valid
    );

endinterface

//--- design/i2c_frame_ctrl.sv
`timescale 1ns/1ps

module i2c_frame_ctrl (
    input  logic clk,
    input  logic reset_p,
    input  logic i_valid,
    input  logic i_rw,
    input  logic i_tx_msb,
    output logic o_busy,
    output logic o_load,
    output logic o_shift_tx,
    output logic o_rx_done,
    i2c_slot_if.ctrl slot_if
);

    logic [i2c_pkg::SEG_W-1:0] r_seg;
    logic [$clog2(i2c_pkg::DATA_W)-1:0] r_bit_cnt;
    logic r_rw;
    logic last_bit;
    logic seg_tx;

    assign last_bit = int'(r_bit_cnt) == i2c_pkg::DATA_W - 1;
    assign seg_tx = (r_seg == i2c_pkg::SEG_ADDR) || (r_seg == i2c_pkg::SEG_WRITE);

    assign o_busy = r_seg != i2c_pkg::SEG_IDLE;
    assign o_load = (r_seg == i2c_pkg::SEG_IDLE) && i_valid;
    assign o_shift_tx = slot_if.slot_end && seg_tx;
    // coincides with rx_valid of the eighth read bit
    assign o_rx_done = slot_if.slot_end && (r_seg == i2c_pkg::SEG_READ) && last_bit;

    always_comb begin
        case (r_seg)
            i2c_pkg::SEG_IDLE:  slot_if.slot_kind = i2c_pkg::SLOT_IDLE;
            i2c_pkg::SEG_START: slot_if.slot_kind = i2c_pkg::SLOT_START;
            i2c_pkg::SEG_STOP:  slot_if.slot_kind = i2c_pkg::SLOT_STOP;
            default:            slot_if.slot_kind = i2c_pkg::SLOT_BIT;
        endcase
    end

    // ack and read slots leave the line released
    assign slot_if.tx_bit = seg_tx ? i_tx_msb : 1'b1;
    assign slot_if.sample_en = r_seg == i2c_pkg::SEG_READ;

    always_ff @(posedge clk or posedge reset_p) begin
        if (reset_p) begin
            r_seg <= i2c_pkg::SEG_IDLE;
            r_bit_cnt <= '0;
            r_rw <= 1'b0;
        end else begin
            case (r_seg)
                i2c_pkg::SEG_IDLE: begin
                    if (i_valid) begin
                        r_seg <= i2c_pkg::SEG_START;
                        r_rw <= i_rw;
                    end
                end
                i2c_pkg::SEG_START: begin
                    if (slot_if.slot_end) begin
                        r_seg <= i2c_pkg::SEG_ADDR;
                        r_bit_cnt <= '0;
                    end
                end
                i2c_pkg::SEG_ADDR: begin
                    // seven address bits followed by the rw bit
                    if (slot_if.slot_end) begin
                        r_bit_cnt <= r_bit_cnt + 1'b1;
                        if (last_bit) begin
                            r_seg <= i2c_pkg::SEG_ACK1;
                        end
                    end
                end
                i2c_pkg::SEG_ACK1: begin
                    if (slot_if.slot_end) begin
                        r_seg <= r_rw ? i2c_pkg::SEG_READ : i2c_pkg::SEG_WRITE;
                    end
                end
                i2c_pkg::SEG_WRITE, i2c_pkg::SEG_READ: begin
                    // counter wraps back to zero after the last bit
                    if (slot_if.slot_end) begin
                        r_bit_cnt <= r_bit_cnt + 1'b1;
                        if (last_bit) begin
                            r_seg <= i2c_pkg::SEG_ACK2;
                        end
                    end
                end
                i2c_pkg::SEG_ACK2: begin
                    if (slot_if.slot_end) begin
                        r_seg <= i2c_pkg::SEG_STOP;
                    end
                end
                i2c_pkg::SEG_STOP: begin
                    if (slot_if.slot_end) begin
                        r_seg <= i2c_pkg::SEG_IDLE;
                    end
                end
                default: begin
                    r_seg <= i2c_pkg::SEG_IDLE;
                end
            endcase
        end
    end

endmodule

//--- design/i2c_bit_engine.sv
`timescale 1ns/1ps

module i2c_bit_engine (
    input  logic clk,
    input  logic reset_p,
    input  logic i_sda,
    output logic o_scl,
    output logic o_sda_oe,
    i2c_slot_if.engine slot_if
);

    logic [i2c_pkg::PHASE_W-1:0] r_quarter;
    logic running;
    logic scl_mid;
    logic scl_next;
    logic oe_next;

    assign running = slot_if.slot_kind != i2c_pkg::SLOT_IDLE;
    assign slot_if.slot_end = running && (int'(r_quarter) == i2c_pkg::QUARTERS - 1);

    // scl is high in quarters 1 and 2 of a normal slot
    assign scl_mid = r_quarter[1] ^ r_quarter[0];

    always_comb begin
        case (slot_if.slot_kind)
            i2c_pkg::SLOT_START: begin
                scl_next = scl_mid;
                oe_next = r_quarter[1];
            end
            i2c_pkg::SLOT_BIT: begin
                scl_next = scl_mid;
                oe_next = ~slot_if.tx_bit;
            end
            i2c_pkg::SLOT_STOP: begin
                // scl stays high once raised, sda released in the second half
                scl_next = r_quarter != '0;
                oe_next = ~r_quarter[1];
            end
            default: begin
                scl_next = 1'b1;
                oe_next = 1'b0;
            end
        endcase
    end

    always_ff @(posedge clk or posedge reset_p) begin
        if (reset_p) begin
            r_quarter <= '0;
            o_scl <= 1'b1;
            o_sda_oe <= 1'b0;
            slot_if.rx_valid <= 1'b0;
        end else begin
            r_quarter <= running ? r_quarter + 1'b1 : '0;
            o_scl <= scl_next;
            o_sda_oe <= oe_next;
            slot_if.rx_valid <= slot_if.sample_en && (int'(r_quarter) == 2);
        end
    end

    // pin scl has been high for a cycle by the end of quarter 2
    always_ff @(posedge clk) begin
        if (slot_if.sample_en && (int'(r_quarter) == 2)) begin
            slot_if.rx_bit <= i_sda;
        end
    end

endmodule

//--- design/i2c_byte_shifter.sv
`timescale 1ns/1ps

module i2c_byte_shifter (
    input  logic clk,
    input  logic reset_p,
    input  logic [i2c_pkg::ADDR_W-1:0] i_addr,
    input  logic [i2c_pkg::DATA_W-1:0] i_data,
    input  logic i_rw,
    input  logic i_load,
    input  logic i_shift_tx,
    input  logic i_rx_bit,
    input  logic i_rx_valid,
    input  logic i_rx_done,
    output logic o_tx_msb,
    output logic [i2c_pkg::DATA_W-1:0] o_receive
);

    localparam int TX_W = i2c_pkg::ADDR_W + 1 + i2c_pkg::DATA_W;

    // address+rw word on top of the data byte, so the data byte
    // reaches the msb right after the eighth address slot
    logic [TX_W-1:0] r_tx_shift;
    // first seven read bits, the eighth joins them on rx_done
    logic [i2c_pkg::DATA_W-2:0] r_rx_shift;

    assign o_tx_msb = r_tx_shift[TX_W-1];

    always_ff @(posedge clk) begin
        if (i_load) begin
            r_tx_shift <= {i_addr, i_rw, i_data};
        end else if (i_shift_tx) begin
            r_tx_shift <= {r_tx_shift[TX_W-2:0], 1'b1};
        end
    end

    always_ff @(posedge clk) begin
        if (i_rx_valid) begin
            r_rx_shift <= {r_rx_shift[i2c_pkg::DATA_W-3:0], i_rx_bit};
        end
    end

    always_ff @(posedge clk or posedge reset_p) begin
        if (reset_p) begin
            o_receive <= '0;
        end else if (i_rx_done) begin
            o_receive <= {r_rx_shift, i_rx_bit};
        end
    end

endmodule

//--- design/i2c_master.sv
`timescale 1ns/1ps

module i2c_master (
    input  logic clk,
    input  logic reset_p,
    input  logic [i2c_pkg::ADDR_W-1:0] i_addr,
    input  logic [i2c_pkg::DATA_W-1:0] i_data,
    input  logic i_rw,
    input  logic i_valid,
    input  logic i_sda,
    output logic o_scl,
    output logic o_sda_oe,
    output logic o_busy,
    output logic [i2c_pkg::DATA_W-1:0] o_receive
);

    logic load;
    logic shift_tx;
    logic tx_msb;
    logic rx_done;

    i2c_slot_if slot ();

    i2c_frame_ctrl frame_ctrl_inst (
        .clk        (clk),
        .reset_p    (reset_p),
        .i_valid    (i_valid),
        .i_rw       (i_rw),
        .i_tx_msb   (tx_msb),
        .o_busy     (o_busy),
        .o_load     (load),
        .o_shift_tx (shift_tx),
        .o_rx_done  (rx_done),
        .slot_if    (slot.ctrl)
    );

    i2c_bit_engine bit_engine_inst (
        .clk      (clk),
        .reset_p  (reset_p),
        .i_sda    (i_sda),
        .o_scl    (o_scl),
        .o_sda_oe (o_sda_oe),
        .slot_if  (slot.engine)
    );

    // sampled bits go straight from the engine to the shifter
    i2c_byte_shifter byte_shifter_inst (
        .clk        (clk),
        .reset_p    (reset_p),
        .i_addr     (i_addr),
        .i_data     (i_data),
        .i_rw       (i_rw),
        .i_load     (load),
        .i_shift_tx (shift_tx),
        .i_rx_bit   (slot.rx_bit),
        .i_rx_valid (slot.rx_valid),
        .i_rx_done  (rx_done),
        .o_tx_msb   (tx_msb),
        .o_receive  (o_receive)
    );

endmodule

//--- test/tb_i2c_slave_model.sv
`timescale 1ns/1ps

module tb_i2c_slave_model (
    input  logic clk,
    input  logic reset_p,
    input  logic i_scl,
    input  logic i_sda_oe,
    input  logic [7:0] i_read_byte,
    output logic o_sda_pull,
    output logic [7:0] o_frame_cnt,
    output logic [7:0] o_start_cnt,
    output logic [7:0] o_stop_cnt,
    output logic [7:0] o_rise_cnt,
    output logic [6:0] o_addr,
    output logic o_rw,
    output logic [7:0] o_data,
    output logic [7:0] o_oe_errors
);

    logic sda;
    logic prev_scl;
    logic prev_sda;
    logic in_frame;
    logic [7:0] read_shift;
    logic [7:0] slot;
    logic released_slot;

    // open-drain line, either side can pull it low
    assign sda = ~(i_sda_oe | o_sda_pull);

    // slot index while scl is high: rises seen so far, minus the one already counted
    assign slot = prev_scl ? o_rise_cnt - 8'd1 : o_rise_cnt;
    assign released_slot = (slot == 8'd8) || (slot == 8'd17)
        || (o_rw && (slot >= 8'd9) && (slot <= 8'd16));

    // bus pins are sampled mid-cycle, away from the clock edge that moves them
    always @(negedge clk or posedge reset_p) begin
        if (reset_p) begin
            prev_scl <= 1'b1;
            prev_sda <= 1'b1;
            in_frame <= 1'b0;
            read_shift <= '0;
            o_sda_pull <= 1'b0;
            o_frame_cnt <= '0;
            o_start_cnt <= '0;
            o_stop_cnt <= '0;
            o_rise_cnt <= '0;
            o_addr <= '0;
            o_rw <= 1'b0;
            o_data <= '0;
            o_oe_errors <= '0;
        end else begin
            prev_scl <= i_scl;
            prev_sda <= sda;
            if (prev_scl && i_scl && prev_sda && !sda) begin
                // a start inside a frame means sda moved while scl was high
                if (!in_frame) begin
                    o_frame_cnt <= o_frame_cnt + 1'b1;
                    o_start_cnt <= 8'd1;
                    o_stop_cnt <= 8'd0;
                    o_rise_cnt <= 8'd0;
                    o_oe_errors <= 8'd0;
                end else begin
                    o_start_cnt <= o_start_cnt + 1'b1;
                end
                in_frame <= 1'b1;
                read_shift <= i_read_byte;
            end else if (prev_scl && i_scl && !prev_sda && sda) begin
                o_stop_cnt <= o_stop_cnt + 1'b1;
                in_frame <= 1'b0;
                o_sda_pull <= 1'b0;
            end else if (in_frame && !prev_scl && i_scl) begin
                if (o_rise_cnt < 8'd7) begin
                    o_addr <= {o_addr[5:0], sda};
                end else if (o_rise_cnt == 8'd7) begin
                    o_rw <= sda;
                end else if ((o_rise_cnt >= 8'd9) && (o_rise_cnt <= 8'd16)) begin
                    o_data <= {o_data[6:0], sda};
                end
                o_rise_cnt <= o_rise_cnt + 1'b1;
            end else if (in_frame && prev_scl && !i_scl) begin
                // scl just fell, set up the next read data bit msb first
                if (o_rw && (o_rise_cnt >= 8'd9) && (o_rise_cnt <= 8'd16)) begin
                    o_sda_pull <= ~read_shift[7];
                    read_shift <= {read_shift[6:0], 1'b0};
                end else begin
                    o_sda_pull <= 1'b0;
                end
            end
            if (in_frame && i_scl && released_slot && i_sda_oe) begin
                o_oe_errors <= o_oe_errors + 1'b1;
            end
        end
    end

endmodule

//--- test/tb_i2c_master.sv
`timescale 1ns/1ps

module tb_i2c_master;

    localparam int N_TRANSFERS = 40;
    localparam int SLOTS_PER_FRAME = 20;
    localparam int FRAME_CYCLES = SLOTS_PER_FRAME * 4;
    // eighteen bit clocks plus the clock raised for the stop
    localparam int RISES_PER_FRAME = 19;
    localparam int RESET_CYCLES = 8;
    localparam int TIMEOUT_CYCLES = N_TRANSFERS * (FRAME_CYCLES + 10) + 20;
    localparam logic [31:0] SEED = 32'hb10965bd;

    logic clk = 1'b0;
    logic reset_p;
    logic [6:0] i_addr;
    logic [7:0] i_data;
    logic i_rw;
    logic i_valid;
    logic i_sda;
    logic o_scl;
    logic o_sda_oe;
    logic o_busy;
    logic [7:0] o_receive;

    logic sda_pull;
    logic [7:0] read_byte;
    logic [7:0] mon_frame_cnt;
    logic [7:0] mon_start_cnt;
    logic [7:0] mon_stop_cnt;
    logic [7:0] mon_rise_cnt;
    logic [6:0] mon_addr;
    logic mon_rw;
    logic [7:0] mon_data;
    logic [7:0] mon_oe_errors;

    logic [31:0] lfsr;
    logic [7:0] expected_receive;
    int frames;
    int cycle_count = 0;

    always #50 clk = ~clk;

    assign i_sda = ~(o_sda_oe | sda_pull);

    i2c_master i2c_master_inst (
        .clk       (clk),
        .reset_p   (reset_p),
        .i_addr    (i_addr),
        .i_data    (i_data),
        .i_rw      (i_rw),
        .i_valid   (i_valid),
        .i_sda     (i_sda),
        .o_scl     (o_scl),
        .o_sda_oe  (o_sda_oe),
        .o_busy    (o_busy),
        .o_receive (o_receive)
    );

    tb_i2c_slave_model slave_inst (
        .clk         (clk),
        .reset_p     (reset_p),
        .i_scl       (o_scl),
        .i_sda_oe    (o_sda_oe),
        .i_read_byte (read_byte),
        .o_sda_pull  (sda_pull),
        .o_frame_cnt (mon_frame_cnt),
        .o_start_cnt (mon_start_cnt),
        .o_stop_cnt  (mon_stop_cnt),
        .o_rise_cnt  (mon_rise_cnt),
        .o_addr      (mon_addr),
        .o_rw        (mon_rw),
        .o_data      (mon_data),
        .o_oe_errors (mon_oe_errors)
    );

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= TIMEOUT_CYCLES) begin
            $display("timeout: transfers did not complete within %0d cycles", TIMEOUT_CYCLES);
            $display("CHECKS FAILED");
            $fatal(1, "run stopped by the cycle limit");
        end
    end

    // fibonacci lfsr with taps 32 22 2 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] state);
        return {state[30:0], state[31] ^ state[21] ^ state[1] ^ state[0]};
    endfunction

    task automatic take_bits(input int n, output logic [31:0] value);
        value = '0;
        for (int i = 0; i < n; i++) begin
            lfsr = lfsr_next(lfsr);
            value = {value[30:0], lfsr[0]};
        end
    endtask

    task automatic check(input string name, input logic [31:0] got,
                         input logic [31:0] expected);
        if (got !== expected) begin
            $display("FAIL time=%0t %s got=%0h expected=%0h", $time, name, got, expected);
            $display("CHECKS FAILED");
            $fatal(1, "mismatch on %s", name);
        end
    endtask

    task automatic run_transfer(input logic [6:0] addr, input logic [7:0] data,
                                input logic rw, input logic [7:0] rd,
                                input logic poke, input int poke_at);
        int busy_cycles;
        busy_cycles = 0;
        read_byte = rd;
        i_addr = addr;
        i_data = data;
        i_rw = rw;
        i_valid = 1'b1;
        @(negedge clk);
        i_valid = 1'b0;
        while (o_busy) begin
            busy_cycles++;
            // a second request with other values must be dropped
            if (poke && (busy_cycles == poke_at)) begin
                i_addr = ~addr;
                i_data = ~data;
                i_rw = ~rw;
                i_valid = 1'b1;
            end else begin
                i_valid = 1'b0;
            end
            @(negedge clk);
        end
        i_valid = 1'b0;
        frames++;
        if (rw) begin
            expected_receive = rd;
        end
        check("o_busy cycles", busy_cycles, FRAME_CYCLES);
        check("monitor frame count", 32'(mon_frame_cnt), frames);
        check("monitor start count", 32'(mon_start_cnt), 1);
        check("monitor stop count", 32'(mon_stop_cnt), 1);
        check("monitor scl rises", 32'(mon_rise_cnt), RISES_PER_FRAME);
        check("monitor address", 32'(mon_addr), 32'(addr));
        check("monitor rw", 32'(mon_rw), 32'(rw));
        check("monitor data byte", 32'(mon_data), rw ? 32'(rd) : 32'(data));
        check("o_sda_oe in released slots", 32'(mon_oe_errors), 0);
        check("o_receive", 32'(o_receive), 32'(expected_receive));
    endtask

    initial begin
        logic [31:0] r;
        logic [6:0] addr;
        logic [7:0] data;
        logic rw;
        logic [7:0] rd;
        logic poke;
        int poke_at;
        reset_p = 1'b1;
        i_addr = '0;
        i_data = '0;
        i_rw = 1'b0;
        i_valid = 1'b0;
        read_byte = '0;
        lfsr = SEED;
        frames = 0;
        expected_receive = '0;
        repeat (RESET_CYCLES) @(negedge clk);
        reset_p = 1'b0;
        @(negedge clk);
        check("o_scl", 32'(o_scl), 1);
        check("o_sda_oe", 32'(o_sda_oe), 0);
        check("o_busy", 32'(o_busy), 0);
        check("o_receive", 32'(o_receive), 0);
        for (int t = 0; t < N_TRANSFERS; t++) begin
            take_bits(7, r);
            addr = r[6:0];
            take_bits(8, r);
            data = r[7:0];
            take_bits(1, r);
            rw = r[0];
            take_bits(8, r);
            rd = r[7:0];
            take_bits(1, r);
            poke = r[0];
            take_bits(6, r);
            poke_at = int'(r[5:0]) + 1;
            run_transfer(addr, data, rw, rd, poke, poke_at);
        end
        // no frame may follow the last one
        repeat (5) @(negedge clk);
        check("monitor frame count", 32'(mon_frame_cnt), frames);
        check("o_busy", 32'(o_busy), 0);
        $display("ALL CHECKS PASSED");
        $finish;
    end

endmodule

//--- src.f
design/i2c_pkg.sv
design/i2c_slot_if.sv
design/i2c_frame_ctrl.sv
design/i2c_bit_engine.sv
design/i2c_byte_shifter.sv
design/i2c_master.sv
test/tb_i2c_slave_model.sv
test/tb_i2c_master.sv

//--- Makefile
TOP := tb_i2c_master

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing -f src.f --top-module $(TOP)

sim: obj_dir/V$(TOP)
	./obj_dir/V$(TOP)

obj_dir/V$(TOP): src.f design/*.sv test/*.sv
	verilator --binary --timing -f src.f --top-module $(TOP) -Mdir obj_dir

clean:
	rm -rf obj_dir
